//--- rtl/core_cfg_pkg.sv
// settings word layout, speed and wait-state encodings, clock-rate constants
package core_cfg_pkg;

	// cpu slow-down divisor where 0 runs at full speed
	typedef logic [4:0] speed_div_t;

	// 64-bit settings word as sent by the io controller
	// first member sits at the top and reset_req is bit 0
	typedef struct packed {
		logic [52:0] spare;
		logic        adlib_hide;
		logic        uart_is_com1;
		logic        joy_swap;
		logic        fake286;
		logic [1:0]  isa_wait_sel;
		logic [2:0]  speed_sel;
		logic        nmi_req;
		logic        reset_req;
	} settings_t;

	// serial port role selected by uart_is_com1
	localparam logic UART_SEL_COM1 = 1'b1;

	// divisor per speed_sel value with index 0 on the right
	// max, /2, /3, /4, /8, /16, /32, and 7 falls back to max
	localparam logic [7:0][4:0] SPEED_DIV = {
		5'd0, 5'd31, 5'd15, 5'd7, 5'd3, 5'd2, 5'd1, 5'd0
	};

	// isa bus wait counts of roughly 1, 2, 3 and 4 us at 50 MHz
	localparam logic [3:0][7:0] WAIT_STATES = {
		8'd200, 8'd166, 8'd100, 8'd50
	};

	// default core clock
	localparam int unsigned CPU_CLK_HZ = 50_000_000;

	// fm synth enable at 3.58 MHz out of 50 MHz
	localparam int unsigned OPL_INC = 358;
	localparam int unsigned OPL_MOD = 5000;

	// audio sample enable uses the core clock rate as modulus
	localparam int unsigned AUDIO_INC = 44100;

endpackage

//--- rtl/io_types_pkg.sv
// packed structs for download bytes, firmware words, joystick inputs and cpu control
package io_types_pkg;

	// one byte of the firmware download
	typedef struct packed {
		logic        active;
		logic        wr;
		logic [24:0] addr;
		logic [7:0]  data;
	} ioctl_t;

	// one firmware word towards the cpu
	typedef struct packed {
		logic [13:0] addr;
		logic [15:0] din;
		logic        wr;
	} bios_xfer_t;

	// two pads whose analog words carry signed X in the high byte and Y in the low byte
	typedef struct packed {
		logic [15:0] analog0;
		logic [15:0] analog1;
		logic [7:0]  digital0;
		logic [7:0]  digital1;
	} joy_in_t;

	// static configuration and reset for the cpu system
	typedef struct packed {
		core_cfg_pkg::speed_div_t speed;
		logic [7:0]               waitstates;
		logic                     fake286;
		logic                     adlib_hide;
		logic                     core_reset;
	} cpu_ctrl_t;

endpackage

//--- rtl/settings_decoder.sv
// settings word decode, core reset generation and serial routing
module settings_decoder (
	input  logic                    clk_cpu,
	input  logic                    arst_n_i,
	input  core_cfg_pkg::settings_t settings_i,
	input  logic                    button_reset_i,
	input  logic                    bios_loaded_i,
	input  logic                    uart_rx_i,
	input  logic                    com1_tx_i,
	input  logic                    mpu_tx_i,
	output io_types_pkg::cpu_ctrl_t ctrl_o,
	output logic                    uart_tx_o,
	output logic                    com1_rx_o,
	output logic                    mpu_rx_o
);
	import core_cfg_pkg::*;

	speed_div_t speed_q;
	logic [7:0] waitstates_q;
	logic       adlib_hide_q;
	logic [1:0] fake286_sync;
	logic       core_reset_q;
	logic       midi_sel;

	always_ff @(posedge clk_cpu or negedge arst_n_i) begin
		if (!arst_n_i) begin
			speed_q      <= '0;
			waitstates_q <= WAIT_STATES[0];
			adlib_hide_q <= 1'b0;
			fake286_sync <= '0;
			// hold the core in reset until the firmware is in
			core_reset_q <= 1'b1;
		end else begin
			speed_q      <= SPEED_DIV[settings_i.speed_sel];
			waitstates_q <= WAIT_STATES[settings_i.isa_wait_sel];
			adlib_hide_q <= settings_i.adlib_hide;
			// fake286 is read by the cpu at odd moments so it gets two stages
			fake286_sync <= {fake286_sync[0], settings_i.fake286};
			core_reset_q <= settings_i.reset_req | button_reset_i | ~bios_loaded_i;
		end
	end

	assign ctrl_o = '{
		speed:      speed_q,
		waitstates: waitstates_q,
		fake286:    fake286_sync[1],
		adlib_hide: adlib_hide_q,
		core_reset: core_reset_q
	};

	// one physical uart shared by com1 and the midi port
	assign midi_sel = (settings_i.uart_is_com1 != UART_SEL_COM1);

	// unused receiver idles high
	assign uart_tx_o = midi_sel ? mpu_tx_i : com1_tx_i;
	assign com1_rx_o = midi_sel ? 1'b1 : uart_rx_i;
	assign mpu_rx_o  = midi_sel ? uart_rx_i : 1'b1;

endmodule

//--- rtl/clock_enable_gen.sv
// fractional accumulator producing a one-cycle clock enable
module clock_enable_gen #(
	parameter int unsigned INCREMENT = 1,
	parameter int unsigned MODULUS   = 2
) (
	input  logic clk_cpu,
	input  logic arst_n_i,
	output logic ce_o
);
	// accumulator never holds more than MODULUS + INCREMENT - 1
	localparam int ACC_W = $clog2(MODULUS + INCREMENT);
	localparam logic [ACC_W-1:0] INC_W = ACC_W'(INCREMENT);
	localparam logic [ACC_W-1:0] MOD_W = ACC_W'(MODULUS);

	logic [ACC_W-1:0] acc_q;
	logic [ACC_W-1:0] acc_next;

	assign acc_next = acc_q + INC_W;

	always_ff @(posedge clk_cpu or negedge arst_n_i) begin
		if (!arst_n_i) begin
			acc_q <= '0;
			ce_o  <= 1'b0;
		end else if (acc_next >= MOD_W) begin
			acc_q <= acc_next - MOD_W;
			ce_o  <= 1'b1;
		end else begin
			acc_q <= acc_next;
			ce_o  <= 1'b0;
		end
	end

endmodule

//--- rtl/bios_loader.sv
// byte pairing, 64-word staging buffer and firmware word stream
module bios_loader (
	input  logic                     clk_cpu,
	input  logic                     arst_n_i,
	input  io_types_pkg::ioctl_t     ioctl_i,
	input  logic                     bios_req_i,
	output io_types_pkg::bios_xfer_t bios_o,
	output logic                     bios_loaded_o
);
	localparam int BUF_WORDS = 64;

	logic [15:0] word_buf [BUF_WORDS];
	logic [7:0]  low_byte;
	logic [15:0] din_q;
	logic [13:0] addr_q;
	logic        wr_q;
	logic        active_d;
	logic        req_d;
	logic        loaded_q;
	logic        byte_wr;
	logic        half_full;
	logic        pull;

	assign byte_wr = ioctl_i.active & ioctl_i.wr;
	// high byte of the last word in either 32-word half
	assign half_full = byte_wr & ioctl_i.addr[0] & (&ioctl_i.addr[5:1]);
	assign pull = ioctl_i.active & bios_req_i;

	// even address keeps the low byte and odd address writes the pair
	always_ff @(posedge clk_cpu) begin
		if (byte_wr) begin
			if (ioctl_i.addr[0]) begin
				word_buf[ioctl_i.addr[6:1]] <= {ioctl_i.data, low_byte};
			end else begin
				low_byte <= ioctl_i.data;
			end
		end
		if (pull) begin
			din_q <= word_buf[addr_q[5:0]];
		end
	end

	always_ff @(posedge clk_cpu or negedge arst_n_i) begin
		if (!arst_n_i) begin
			addr_q   <= '0;
			wr_q     <= 1'b0;
			active_d <= 1'b0;
			req_d    <= 1'b0;
			loaded_q <= 1'b0;
		end else begin
			active_d <= ioctl_i.active;
			req_d    <= bios_req_i;
			// new download starts the stream over
			if (ioctl_i.active & ~active_d) begin
				addr_q <= '0;
				wr_q   <= 1'b0;
			end
			if (active_d & ~ioctl_i.active) begin
				loaded_q <= 1'b1;
			end
			if (half_full) begin
				wr_q <= 1'b1;
			end
			// cpu drops its request once it has drained the half
			if (req_d & ~bios_req_i) begin
				wr_q <= 1'b0;
			end
			if (pull) begin
				addr_q <= addr_q + 14'd1;
			end
		end
	end

	assign bios_o = '{addr: addr_q, din: din_q, wr: wr_q};
	assign bios_loaded_o = loaded_q;

endmodule

//--- rtl/joystick_port.sv
// analog axis one-shot timers and button inputs of the game port
module joystick_port (
	input  logic                     clk_cpu,
	input  logic                     arst_n_i,
	input  io_types_pkg::joy_in_t    joy_i,
	input  logic                     joy_swap_i,
	input  core_cfg_pkg::speed_div_t speed_i,
	input  logic                     joy_wr_i,
	output logic [7:0]               joy_o
);
	localparam logic [7:0] CNT_STOP = 8'hFF;

	logic [15:0]     pad0;
	logic [15:0]     pad1;
	logic [3:0]      btn_n;
	logic [3:0][7:0] axis_bias;
	logic [7:0]      joy_q;
	logic [7:0]      axis_cnt;
	logic [8:0]      pre_cnt;
	logic            pre_ce;

	assign pad0 = joy_swap_i ? joy_i.analog1 : joy_i.analog0;
	assign pad1 = joy_swap_i ? joy_i.analog0 : joy_i.analog1;

	// buttons are active low on the port
	assign btn_n = joy_swap_i ? ~{joy_i.digital1[5:4], joy_i.digital0[5:4]} :
		~{joy_i.digital0[5:4], joy_i.digital1[5:4]};

	// signed axis moved to 0..255 with centre at 128
	assign axis_bias[0] = {~pad1[15], pad1[14:8]};
	assign axis_bias[1] = {~pad1[7], pad1[6:0]};
	assign axis_bias[2] = {~pad0[15], pad0[14:8]};
	assign axis_bias[3] = {~pad0[7], pad0[6:0]};

	always_ff @(posedge clk_cpu or negedge arst_n_i) begin
		if (!arst_n_i) begin
			joy_q    <= 8'hFF;
			axis_cnt <= CNT_STOP;
			pre_cnt  <= '0;
			pre_ce   <= 1'b0;
		end else begin
			joy_q[7:4] <= btn_n;
			// prescaler period is (speed + 1) * 16
			pre_cnt <= pre_cnt + 9'd1;
			if (pre_cnt == {speed_i, 4'hF}) begin
				pre_cnt <= '0;
			end
			pre_ce <= (pre_cnt == '0);
			if (joy_wr_i) begin
				// write to the port fires all four one-shots
				joy_q[3:0] <= 4'hF;
				axis_cnt   <= '0;
				pre_cnt    <= 9'd1;
				pre_ce     <= 1'b0;
			end else if (axis_cnt != CNT_STOP) begin
				for (int i = 0; i < 4; i++) begin
					if (axis_cnt == axis_bias[i]) begin
						joy_q[i] <= 1'b0;
					end
				end
				if (pre_ce) begin
					axis_cnt <= axis_cnt + 8'd1;
				end
			end else begin
				joy_q[3:0] <= '0;
			end
		end
	end

	assign joy_o = joy_q;

endmodule

//--- rtl/nmi_stretcher.sv
// rising-edge detect on the NMI request and long pulse generation
module nmi_stretcher #(
	parameter int unsigned NMI_PULSE_CYCLES = 16_777_215
) (
	input  logic clk_cpu,
	input  logic arst_n_i,
	input  logic nmi_req_i,
	output logic nmi_o
);
	localparam int CNT_W = $clog2(NMI_PULSE_CYCLES + 1);

	logic [CNT_W-1:0] pulse_cnt;
	logic             req_d;
	logic             req_rise;

	assign req_rise = nmi_req_i & ~req_d;

	always_ff @(posedge clk_cpu or negedge arst_n_i) begin
		if (!arst_n_i) begin
			pulse_cnt <= '0;
			req_d     <= 1'b0;
			nmi_o     <= 1'b0;
		end else begin
			req_d <= nmi_req_i;
			if (pulse_cnt == '0) begin
				nmi_o <= 1'b0;
				// new edges only count once the pulse is over
				if (req_rise) begin
					pulse_cnt <= CNT_W'(NMI_PULSE_CYCLES);
				end
			end else begin
				nmi_o     <= 1'b1;
				pulse_cnt <= pulse_cnt - CNT_W'(1);
			end
		end
	end

endmodule

//--- rtl/retro_glue_top.sv
// top level of the board-side control logic of the retro pc core
module retro_glue_top #(
	parameter int unsigned CLK_HZ           = core_cfg_pkg::CPU_CLK_HZ,
	parameter int unsigned NMI_PULSE_CYCLES = 16_777_215
) (
	input  logic                     clk_cpu,
	input  logic                     arst_n_i,
	input  core_cfg_pkg::settings_t  settings_i,
	input  logic                     button_reset_i,
	input  io_types_pkg::ioctl_t     ioctl_i,
	input  logic                     bios_req_i,
	input  io_types_pkg::joy_in_t    joy_i,
	input  logic                     joy_wr_i,
	input  logic                     uart_rx_i,
	input  logic                     com1_tx_i,
	input  logic                     mpu_tx_i,
	output io_types_pkg::cpu_ctrl_t  ctrl_o,
	output io_types_pkg::bios_xfer_t bios_o,
	output logic [7:0]               joy_o,
	output logic                     opl_ce_o,
	output logic                     audio_ce_o,
	output logic                     nmi_o,
	output logic                     uart_tx_o,
	output logic                     com1_rx_o,
	output logic                     mpu_rx_o
);
	import core_cfg_pkg::*;

	logic bios_loaded;

	settings_decoder i_settings_decoder (
		.clk_cpu        (clk_cpu),
		.arst_n_i       (arst_n_i),
		.settings_i     (settings_i),
		.button_reset_i (button_reset_i),
		.bios_loaded_i  (bios_loaded),
		.uart_rx_i      (uart_rx_i),
		.com1_tx_i      (com1_tx_i),
		.mpu_tx_i       (mpu_tx_i),
		.ctrl_o         (ctrl_o),
		.uart_tx_o      (uart_tx_o),
		.com1_rx_o      (com1_rx_o),
		.mpu_rx_o       (mpu_rx_o)
	);

	bios_loader i_bios_loader (
		.clk_cpu       (clk_cpu),
		.arst_n_i      (arst_n_i),
		.ioctl_i       (ioctl_i),
		.bios_req_i    (bios_req_i),
		.bios_o        (bios_o),
		.bios_loaded_o (bios_loaded)
	);

	// axis timer runs at the decoded cpu speed
	joystick_port i_joystick_port (
		.clk_cpu    (clk_cpu),
		.arst_n_i   (arst_n_i),
		.joy_i      (joy_i),
		.joy_swap_i (settings_i.joy_swap),
		.speed_i    (ctrl_o.speed),
		.joy_wr_i   (joy_wr_i),
		.joy_o      (joy_o)
	);

	nmi_stretcher #(
		.NMI_PULSE_CYCLES (NMI_PULSE_CYCLES)
	) i_nmi_stretcher (
		.clk_cpu   (clk_cpu),
		.arst_n_i  (arst_n_i),
		.nmi_req_i (settings_i.nmi_req),
		.nmi_o     (nmi_o)
	);

	clock_enable_gen #(
		.INCREMENT (OPL_INC),
		.MODULUS   (OPL_MOD)
	) i_opl_ce (
		.clk_cpu  (clk_cpu),
		.arst_n_i (arst_n_i),
		.ce_o     (opl_ce_o)
	);

	clock_enable_gen #(
		.INCREMENT (AUDIO_INC),
		.MODULUS   (CLK_HZ)
	) i_audio_ce (
		.clk_cpu  (clk_cpu),
		.arst_n_i (arst_n_i),
		.ce_o     (audio_ce_o)
	);

endmodule

//--- testbench/tb_retro_glue.sv
// clock, reset, directed test tasks, checks and summary for the retro glue top level
module tb_retro_glue;
	timeunit 1ns;
	timeprecision 1ps;

	import core_cfg_pkg::*;
	import io_types_pkg::*;

	// well above the roughly 19k cycles of all tests
	localparam int TIMEOUT_CYCLES = 200_000;
	localparam int NMI_CYCLES     = 20;
	localparam int JOY_LIMIT      = 256 * 16 + 10;
	localparam int CE_WINDOW      = 10_000;
	// fm synth and audio sample enable rates
	localparam int FM_STEP        = 358;
	localparam int FM_MOD         = 5000;
	localparam int SAMPLE_STEP    = 44_100;
	localparam int CLK_RATE       = 50_000_000;

	logic       clk_cpu = 1'b0;
	logic       arst_n_i;
	settings_t  settings;
	logic       button_reset;
	ioctl_t     ioctl;
	logic       bios_req;
	joy_in_t    joy_in;
	logic       joy_wr;
	logic       uart_rx;
	logic       com1_tx;
	logic       mpu_tx;
	cpu_ctrl_t  ctrl;
	bios_xfer_t bios;
	logic [7:0] joy;
	logic       opl_ce;
	logic       audio_ce;
	logic       nmi;
	logic       uart_tx;
	logic       com1_rx;
	logic       mpu_rx;
	int         checks = 0;
	int         errors = 0;
	int         cycle_cnt = 0;

	retro_glue_top #(
		.NMI_PULSE_CYCLES (NMI_CYCLES)
	) i_retro_glue_top (
		.clk_cpu        (clk_cpu),
		.arst_n_i       (arst_n_i),
		.settings_i     (settings),
		.button_reset_i (button_reset),
		.ioctl_i        (ioctl),
		.bios_req_i     (bios_req),
		.joy_i          (joy_in),
		.joy_wr_i       (joy_wr),
		.uart_rx_i      (uart_rx),
		.com1_tx_i      (com1_tx),
		.mpu_tx_i       (mpu_tx),
		.ctrl_o         (ctrl),
		.bios_o         (bios),
		.joy_o          (joy),
		.opl_ce_o       (opl_ce),
		.audio_ce_o     (audio_ce),
		.nmi_o          (nmi),
		.uart_tx_o      (uart_tx),
		.com1_rx_o      (com1_rx),
		.mpu_rx_o       (mpu_rx)
	);

	always #50 clk_cpu = ~clk_cpu;

	always @(posedge clk_cpu) begin
		cycle_cnt = cycle_cnt + 1;
		if (cycle_cnt > TIMEOUT_CYCLES) begin
			$display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("=== FAIL ===");
			$finish;
		end
	end

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("ERROR %s: got %h, expected %h", name, got, expected);
		end
	endtask

	task automatic report_failure(input string what);
		errors++;
		$display("failure: %s", what);
	endtask

	function automatic logic [4:0] speed_divisor(input logic [2:0] sel);
		case (sel)
			3'd1: return 5'd1;
			3'd2: return 5'd2;
			3'd3: return 5'd3;
			3'd4: return 5'd7;
			3'd5: return 5'd15;
			3'd6: return 5'd31;
			default: return 5'd0;
		endcase
	endfunction

	function automatic logic [7:0] wait_count(input logic [1:0] sel);
		case (sel)
			2'd0: return 8'd50;
			2'd1: return 8'd100;
			2'd2: return 8'd166;
			default: return 8'd200;
		endcase
	endfunction

	// signed axis byte moved to 0..255
	function automatic logic [7:0] biased(input logic [7:0] axis);
		return {~axis[7], axis[6:0]};
	endfunction

	task automatic verify_reset_state();
		check_value("ctrl_o.core_reset", 64'(ctrl.core_reset), 64'(1));
		check_value("bios_o.wr", 64'(bios.wr), 64'(0));
		check_value("joy_o", 64'(joy), 64'(8'hFF));
		check_value("nmi_o", 64'(nmi), 64'(0));
		check_value("opl_ce_o", 64'(opl_ce), 64'(0));
		check_value("audio_ce_o", 64'(audio_ce), 64'(0));
	endtask

	task automatic decode_settings();
		for (int s = 0; s < 8; s++) begin
			@(negedge clk_cpu);
			settings.speed_sel = 3'(s);
			@(negedge clk_cpu);
			check_value("ctrl_o.speed", 64'(ctrl.speed), 64'(speed_divisor(3'(s))));
		end
		for (int w = 0; w < 4; w++) begin
			@(negedge clk_cpu);
			settings.isa_wait_sel = 2'(w);
			@(negedge clk_cpu);
			check_value("ctrl_o.waitstates", 64'(ctrl.waitstates), 64'(wait_count(2'(w))));
		end
		// fake286 goes through two stages
		settings.fake286 = 1'b1;
		settings.adlib_hide = 1'b1;
		settings.speed_sel = 3'd0;
		@(negedge clk_cpu);
		check_value("ctrl_o.fake286", 64'(ctrl.fake286), 64'(0));
		check_value("ctrl_o.adlib_hide", 64'(ctrl.adlib_hide), 64'(1));
		settings.adlib_hide = 1'b0;
		@(negedge clk_cpu);
		check_value("ctrl_o.fake286", 64'(ctrl.fake286), 64'(1));
		check_value("ctrl_o.adlib_hide", 64'(ctrl.adlib_hide), 64'(0));
		// core stays in reset without firmware
		check_value("ctrl_o.core_reset", 64'(ctrl.core_reset), 64'(1));
	endtask

	task automatic route_serial_pins();
		for (int v = 0; v < 16; v++) begin
			@(negedge clk_cpu);
			settings.uart_is_com1 = v[3];
			{uart_rx, com1_tx, mpu_tx} = 3'(v);
			#10;
			if (v[3]) begin
				check_value("uart_tx_o", 64'(uart_tx), 64'(com1_tx));
				check_value("com1_rx_o", 64'(com1_rx), 64'(uart_rx));
				check_value("mpu_rx_o", 64'(mpu_rx), 64'(1));
			end else begin
				check_value("uart_tx_o", 64'(uart_tx), 64'(mpu_tx));
				check_value("com1_rx_o", 64'(com1_rx), 64'(1));
				check_value("mpu_rx_o", 64'(mpu_rx), 64'(uart_rx));
			end
		end
	endtask

	task automatic stream_firmware();
		logic [7:0]  fw_bytes [$];
		logic [15:0] word;
		for (int i = 0; i < 128; i++) begin
			fw_bytes.push_back(8'($urandom));
		end
		@(negedge clk_cpu);
		ioctl.active = 1'b1;
		for (int i = 0; i < 128; i++) begin
			// half-full flag comes with the high byte at address 63
			check_value("bios_o.wr", 64'(bios.wr), 64'(i > 63));
			ioctl.wr = 1'b1;
			ioctl.addr = 25'(i);
			ioctl.data = fw_bytes[i];
			@(negedge clk_cpu);
		end
		ioctl.wr = 1'b0;
		check_value("bios_o.wr", 64'(bios.wr), 64'(1));
		bios_req = 1'b1;
		for (int k = 1; k <= 64; k++) begin
			@(negedge clk_cpu);
			word = {fw_bytes[2 * k - 1], fw_bytes[2 * k - 2]};
			check_value("bios_o.din", 64'(bios.din), 64'(word));
			check_value("bios_o.addr", 64'(bios.addr), 64'(k));
		end
		bios_req = 1'b0;
		@(negedge clk_cpu);
		check_value("bios_o.wr", 64'(bios.wr), 64'(0));
		check_value("ctrl_o.core_reset", 64'(ctrl.core_reset), 64'(1));
		ioctl.active = 1'b0;
		@(negedge clk_cpu);
		check_value("ctrl_o.core_reset", 64'(ctrl.core_reset), 64'(1));
		@(negedge clk_cpu);
		check_value("ctrl_o.core_reset", 64'(ctrl.core_reset), 64'(0));
	endtask

	task automatic toggle_core_reset();
		settings.reset_req = 1'b1;
		@(negedge clk_cpu);
		check_value("ctrl_o.core_reset", 64'(ctrl.core_reset), 64'(1));
		settings.reset_req = 1'b0;
		@(negedge clk_cpu);
		check_value("ctrl_o.core_reset", 64'(ctrl.core_reset), 64'(0));
		button_reset = 1'b1;
		@(negedge clk_cpu);
		check_value("ctrl_o.core_reset", 64'(ctrl.core_reset), 64'(1));
		button_reset = 1'b0;
		@(negedge clk_cpu);
		check_value("ctrl_o.core_reset", 64'(ctrl.core_reset), 64'(0));
	endtask

	task automatic time_joystick_axes(input logic swap);
		logic [15:0] pad0;
		logic [15:0] pad1;
		logic [7:0]  dig0;
		logic [7:0]  dig1;
		logic [7:0]  bias [4];
		logic [3:0]  btn;
		int          fall [4];
		int          cycle;
		int          expect_c;
		@(negedge clk_cpu);
		joy_in.analog0 = 16'($urandom);
		joy_in.analog1 = 16'($urandom);
		joy_in.digital0 = 8'($urandom);
		joy_in.digital1 = 8'($urandom);
		settings.joy_swap = swap;
		pad0 = swap ? joy_in.analog1 : joy_in.analog0;
		pad1 = swap ? joy_in.analog0 : joy_in.analog1;
		dig0 = swap ? joy_in.digital1 : joy_in.digital0;
		dig1 = swap ? joy_in.digital0 : joy_in.digital1;
		bias[0] = biased(pad1[15:8]);
		bias[1] = biased(pad1[7:0]);
		bias[2] = biased(pad0[15:8]);
		bias[3] = biased(pad0[7:0]);
		btn = ~{dig0[5:4], dig1[5:4]};
		for (int i = 0; i < 4; i++) begin
			fall[i] = -1;
		end
		joy_wr = 1'b1;
		@(negedge clk_cpu);
		joy_wr = 1'b0;
		check_value("joy_o", 64'(joy), 64'({btn, 4'hF}));
		cycle = 0;
		while (joy[3:0] != 4'h0 && cycle < JOY_LIMIT) begin
			@(negedge clk_cpu);
			cycle++;
			for (int i = 0; i < 4; i++) begin
				if (!joy[i] && fall[i] < 0) begin
					fall[i] = cycle;
				end
			end
		end
		if (joy[3:0] != 4'h0) begin
			report_failure($sformatf("joystick axis bits still set after %0d cycles", JOY_LIMIT));
		end
		// at speed 0 the count steps every 16 cycles
		for (int i = 0; i < 4; i++) begin
			expect_c = 16 * int'(bias[i]);
			if (fall[i] - expect_c > 16 || expect_c - fall[i] > 16) begin
				report_failure($sformatf("joystick axis %0d fell at cycle %0d, value %0d",
					i, fall[i], bias[i]));
			end
		end
		for (int i = 0; i < 4; i++) begin
			for (int j = 0; j < 4; j++) begin
				if (bias[i] < bias[j] && fall[i] >= fall[j]) begin
					report_failure($sformatf("joystick axis %0d fell no earlier than axis %0d",
						i, j));
				end
			end
		end
		check_value("joy_o", 64'(joy), 64'({btn, 4'h0}));
	endtask

	task automatic stretch_nmi();
		int   high_cnt;
		int   rises;
		logic prev;
		high_cnt = 0;
		rises = 0;
		prev = 1'b0;
		@(negedge clk_cpu);
		settings.nmi_req = 1'b1;
		for (int c = 0; c < 3 * NMI_CYCLES; c++) begin
			@(negedge clk_cpu);
			if (nmi) begin
				high_cnt++;
			end
			if (nmi && !prev) begin
				rises++;
			end
			prev = nmi;
			// second request edge while the pulse runs
			if (c == 5) begin
				settings.nmi_req = 1'b0;
			end
			if (c == 8) begin
				settings.nmi_req = 1'b1;
			end
		end
		settings.nmi_req = 1'b0;
		check_value("nmi_o high cycles", 64'(high_cnt), 64'(NMI_CYCLES));
		check_value("nmi_o pulses", 64'(rises), 64'(1));
	endtask

	task automatic count_clock_enables();
		int opl_cnt;
		int audio_cnt;
		int opl_exp;
		int audio_exp;
		opl_cnt = 0;
		audio_cnt = 0;
		opl_exp = CE_WINDOW * FM_STEP / FM_MOD;
		audio_exp = CE_WINDOW * SAMPLE_STEP / CLK_RATE;
		for (int c = 0; c < CE_WINDOW; c++) begin
			@(negedge clk_cpu);
			opl_cnt += int'(opl_ce);
			audio_cnt += int'(audio_ce);
		end
		if (opl_cnt < opl_exp - 1 || opl_cnt > opl_exp + 1) begin
			report_failure($sformatf("opl_ce_o pulsed %0d times, expected %0d give or take 1",
				opl_cnt, opl_exp));
		end
		if (audio_cnt < audio_exp || audio_cnt > audio_exp + 1) begin
			report_failure($sformatf("audio_ce_o pulsed %0d times, expected %0d or %0d",
				audio_cnt, audio_exp, audio_exp + 1));
		end
	endtask

	initial begin
		void'($urandom(32'h22e00476));
		arst_n_i = 1'b0;
		settings = '0;
		button_reset = 1'b0;
		ioctl = '0;
		bios_req = 1'b0;
		joy_in = '0;
		joy_wr = 1'b0;
		uart_rx = 1'b1;
		com1_tx = 1'b1;
		mpu_tx = 1'b1;
		repeat (4) @(negedge clk_cpu);
		verify_reset_state();
		arst_n_i = 1'b1;
		decode_settings();
		route_serial_pins();
		stream_firmware();
		toggle_core_reset();
		time_joystick_axes(1'b0);
		time_joystick_axes(1'b1);
		stretch_nmi();
		count_clock_enables();
		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("=== PASS ===");
		end else begin
			$display("=== FAIL ===");
		end
		$finish;
	end

endmodule

//--- sim.f
rtl/core_cfg_pkg.sv
rtl/io_types_pkg.sv
rtl/settings_decoder.sv
rtl/clock_enable_gen.sv
rtl/bios_loader.sv
rtl/joystick_port.sv
rtl/nmi_stretcher.sv
rtl/retro_glue_top.sv
testbench/tb_retro_glue.sv

//--- Makefile
# Verilator build, run and lint of the retro glue logic
TOP := tb_retro_glue

.PHONY: all lint clean

all:
	verilator --binary --timing -j 0 --top-module $(TOP) -f sim.f
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qF "=== PASS ==="

lint:
	verilator --lint-only --timing --top-module $(TOP) -f sim.f
	verilator --lint-only --top-module retro_glue_top \
		rtl/core_cfg_pkg.sv rtl/io_types_pkg.sv rtl/settings_decoder.sv \
		rtl/clock_enable_gen.sv rtl/bios_loader.sv rtl/joystick_port.sv \
		rtl/nmi_stretcher.sv rtl/retro_glue_top.sv

clean:
	rm -rf obj_dir
